//--- rtl/frame_receiver.sv
`timescale 1ns/1ps
/* control frame receiver with start code and slave id check */
module frame_receiver
    import serial_bus_pkg::*;
#(
    parameter slave_id_t SLAVE_ID = 1
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic accept,
    output logic cmd_valid,
    output cmd_t cmd
);
    localparam int CNT_W = $clog2(FRAME_BITS);

    logic [FRAME_BITS-1:0] shift_q;
    logic [CNT_W-1:0]      bit_cnt;
    logic                  busy;
    logic                  frame_start;
    logic                  frame_end;
    ctrl_frame_t           frame_next;

    // frame contents once the bit on control is shifted in
    assign frame_next  = {shift_q[FRAME_BITS-2:0], control};
    assign frame_start = !busy && accept && control;
    assign frame_end   = busy && (bit_cnt == CNT_W'(FRAME_BITS - 1));

    always_ff @(posedge clk) begin
        if (frame_start || busy) begin
            shift_q <= frame_next;
        end
        if (frame_end) begin
            cmd.write <= frame_next.write;
            cmd.burst <= frame_next.burst;
            cmd.addr  <= frame_next.addr;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy      <= 1'b0;
            bit_cnt   <= '0;
            cmd_valid <= 1'b0;
        end else begin
            // only frames for this slave reach the controller
            cmd_valid <= frame_end && (frame_next.start == START_CODE) &&
                         (frame_next.id == SLAVE_ID);
            if (frame_start) begin
                busy    <= 1'b1;
                bit_cnt <= CNT_W'(1);
            end else if (frame_end) begin
                busy    <= 1'b0;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- rtl/read_serializer.sv
`timescale 1ns/1ps
/* read word serializer driving rD and rd_valid, msb first */
module read_serializer
    import serial_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  load,
    input  data_t load_word,
    output logic  rD,
    output logic  rd_valid,
    output logic  bit_done
);
    localparam int CNT_W = $clog2(DATA_WIDTH);

    data_t            shift_q;
    logic [CNT_W-1:0] bit_cnt;
    logic             active;

    assign rd_valid = active;
    assign rD       = active && shift_q[DATA_WIDTH-1];
    assign bit_done = active && (bit_cnt == CNT_W'(DATA_WIDTH - 1));

    always_ff @(posedge clk) begin
        if (load) begin
            shift_q <= load_word;
        end else if (active) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (load) begin
            active  <= 1'b1;
            bit_cnt <= '0;
        end else if (bit_done) begin
            // word fully sent
            active  <= 1'b0;
            bit_cnt <= '0;
        end else if (active) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

endmodule

//--- rtl/serial_bus_pkg.sv
/* widths, control frame layout, command type and start code
   shared by the serial bus slave */
package serial_bus_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int MEM_DEPTH  = 2 ** ADDR_WIDTH;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH   = 2;

    // start, id, write, burst, addr
    localparam int FRAME_BITS = 3 + ID_WIDTH + 2 + ADDR_WIDTH;

    localparam logic [2:0] START_CODE = 3'b111;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ID_WIDTH-1:0]   slave_id_t;

    // msb is the first bit on the control line
    typedef struct packed {
        logic [2:0] start;
        slave_id_t  id;
        logic       write;
        logic       burst;
        addr_t      addr;
    } ctrl_frame_t;

    // decoded command handed to the controller
    typedef struct packed {
        logic  write;
        logic  burst;
        addr_t addr;
    } cmd_t;

endpackage

//--- rtl/serial_slave.sv
`timescale 1ns/1ps
/* serial bus memory slave top level */
module serial_slave
    import serial_bus_pkg::*;
#(
    parameter slave_id_t SLAVE_ID     = 1,
    parameter int        ACCESS_DELAY = 2
) (
    input  logic clk,
    input  logic rstN,
    input  logic control,
    input  logic wD,
    input  logic valid,
    input  logic last,
    output logic rD,
    output logic rd_valid,
    output logic ready
);
    logic  cmd_valid;
    cmd_t  cmd;
    logic  wr_enable;
    logic  word_valid;
    data_t word;
    logic  word_last;
    addr_t mem_addr;
    logic  mem_rd_en;
    logic  mem_wr_en;
    data_t mem_wr_data;
    data_t rd_data;
    logic  load;
    data_t load_word;
    logic  bit_done;

    // input side
    frame_receiver #(
        .SLAVE_ID(SLAVE_ID)
    ) u_frame_receiver (
        .clk      (clk),
        .rstN     (rstN),
        .control  (control),
        .accept   (ready),
        .cmd_valid(cmd_valid),
        .cmd      (cmd)
    );

    write_deserializer u_write_deserializer (
        .clk       (clk),
        .rstN      (rstN),
        .wD        (wD),
        .valid     (valid),
        .last      (last),
        .wr_enable (wr_enable),
        .word_valid(word_valid),
        .word      (word),
        .word_last (word_last)
    );

    slave_controller #(
        .ACCESS_DELAY(ACCESS_DELAY)
    ) u_slave_controller (
        .clk        (clk),
        .rstN       (rstN),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .word_valid (word_valid),
        .word       (word),
        .word_last  (word_last),
        .bit_done   (bit_done),
        .last       (last),
        .rd_data    (rd_data),
        .ready      (ready),
        .wr_enable  (wr_enable),
        .mem_addr   (mem_addr),
        .mem_rd_en  (mem_rd_en),
        .mem_wr_en  (mem_wr_en),
        .mem_wr_data(mem_wr_data),
        .load       (load),
        .load_word  (load_word)
    );

    slave_memory u_slave_memory (
        .clk    (clk),
        .addr   (mem_addr),
        .rd_en  (mem_rd_en),
        .wr_en  (mem_wr_en),
        .wr_data(mem_wr_data),
        .rd_data(rd_data)
    );

    // output side
    read_serializer u_read_serializer (
        .clk      (clk),
        .rstN     (rstN),
        .load     (load),
        .load_word(load_word),
        .rD       (rD),
        .rd_valid (rd_valid),
        .bit_done (bit_done)
    );

endmodule

//--- rtl/slave_controller.sv
`timescale 1ns/1ps
/* transaction FSM with address counter and memory access wait */
module slave_controller
    import serial_bus_pkg::*;
#(
    parameter int ACCESS_DELAY = 2
) (
    input  logic  clk,
    input  logic  rstN,
    input  logic  cmd_valid,
    input  cmd_t  cmd,
    input  logic  word_valid,
    input  data_t word,
    input  logic  word_last,
    input  logic  bit_done,
    input  logic  last,
    input  data_t rd_data,
    output logic  ready,
    output logic  wr_enable,
    output addr_t mem_addr,
    output logic  mem_rd_en,
    output logic  mem_wr_en,
    output data_t mem_wr_data,
    output logic  load,
    output data_t load_word
);
    localparam int DLY_W = (ACCESS_DELAY > 0) ? $clog2(ACCESS_DELAY + 1) : 1;

    typedef enum logic [2:0] {
        IDLE,
        WRITE_WAIT,
        WRITE_DELAY,
        READ_DELAY,
        READ_FETCH,
        READ_SEND
    } ctrl_state_t;

    ctrl_state_t      state;
    addr_t            addr_q;
    logic             burst_q;
    logic             last_q;
    data_t            wr_data_q;
    logic [DLY_W-1:0] dly_cnt;
    logic             dly_done;

    assign dly_done = (dly_cnt == DLY_W'(ACCESS_DELAY));

    // master may start a frame only while nothing is in flight
    assign ready     = (state == IDLE) && !cmd_valid;
    assign wr_enable = (state == WRITE_WAIT) || (state == WRITE_DELAY);

    assign mem_addr    = addr_q;
    assign mem_wr_data = wr_data_q;
    assign mem_wr_en   = (state == WRITE_DELAY) && dly_done;
    assign mem_rd_en   = (state == READ_DELAY) && dly_done;

    // rd_data is valid the cycle after mem_rd_en
    assign load      = (state == READ_FETCH);
    assign load_word = rd_data;

    always_ff @(posedge clk) begin
        if (state == WRITE_WAIT && word_valid) begin
            wr_data_q <= word;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state   <= IDLE;
            addr_q  <= '0;
            burst_q <= 1'b0;
            last_q  <= 1'b0;
            dly_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    dly_cnt <= '0;
                    if (cmd_valid) begin
                        addr_q  <= cmd.addr;
                        burst_q <= cmd.burst;
                        state   <= cmd.write ? WRITE_WAIT : READ_DELAY;
                    end
                end
                WRITE_WAIT: begin
                    if (word_valid) begin
                        last_q  <= word_last;
                        dly_cnt <= '0;
                        state   <= WRITE_DELAY;
                    end
                end
                WRITE_DELAY: begin
                    if (!dly_done) begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end else if (!burst_q || last_q) begin
                        state <= IDLE;
                    end else begin
                        addr_q <= addr_q + 1'b1;
                        state  <= WRITE_WAIT;
                    end
                end
                READ_DELAY: begin
                    if (!dly_done) begin
                        dly_cnt <= dly_cnt + 1'b1;
                    end else begin
                        state <= READ_FETCH;
                    end
                end
                READ_FETCH: begin
                    state <= READ_SEND;
                end
                READ_SEND: begin
                    // last is sampled with the final bit of each word
                    if (bit_done) begin
                        dly_cnt <= '0;
                        if (!burst_q || last) begin
                            state <= IDLE;
                        end else begin
                            addr_q <= addr_q + 1'b1;
                            state  <= READ_DELAY;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

//--- rtl/slave_memory.sv
`timescale 1ns/1ps
/* word memory, synchronous read and write on one address */
module slave_memory
    import serial_bus_pkg::*;
(
    input  logic  clk,
    input  addr_t addr,
    input  logic  rd_en,
    input  logic  wr_en,
    input  data_t wr_data,
    output data_t rd_data
);
    data_t mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
        // read word is registered for the next cycle
        if (rd_en) begin
            rd_data <= mem[addr];
        end
    end

endmodule

//--- rtl/write_deserializer.sv
`timescale 1ns/1ps
/* write data deserializer, valid qualified, msb first */
module write_deserializer
    import serial_bus_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  logic  wD,
    input  logic  valid,
    input  logic  last,
    input  logic  wr_enable,
    output logic  word_valid,
    output data_t word,
    output logic  word_last
);
    localparam int CNT_W = $clog2(DATA_WIDTH);

    data_t            shift_q;
    logic [CNT_W-1:0] bit_cnt;
    logic             take;
    logic             word_end;

    assign take     = wr_enable && valid;
    assign word_end = take && (bit_cnt == CNT_W'(DATA_WIDTH - 1));

    // complete word sits in the shift register while word_valid is high
    assign word = shift_q;

    always_ff @(posedge clk) begin
        if (take) begin
            shift_q <= {shift_q[DATA_WIDTH-2:0], wD};
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
            word_last  <= 1'b0;
        end else begin
            word_valid <= word_end;
            if (word_end) begin
                word_last <= last;
            end
            if (!wr_enable || word_end) begin
                bit_cnt <= '0;
            end else if (take) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

//--- sim/serial_slave_assertions.sv
`timescale 1ns/1ps
/* concurrent protocol assertions, bound to the slave top level */
module serial_slave_assertions (
    input logic clk,
    input logic rstN,
    input logic ready,
    input logic rd_valid,
    input logic rD
);

    // read bits only go out inside a transaction
    a_no_read_while_ready: assert property (
        @(posedge clk) disable iff (!rstN) rd_valid |-> !ready
    ) else $error("rd_valid high while ready is high");

    a_ready_after_reset: assert property (
        @(posedge clk) $rose(rstN) |-> ready
    ) else $error("ready low in the cycle after reset release");

    a_rd_known: assert property (
        @(posedge clk) disable iff (!rstN) rd_valid |-> !$isunknown(rD)
    ) else $error("rD unknown while rd_valid is high");

endmodule

bind serial_slave serial_slave_assertions u_assertions (
    .clk     (clk),
    .rstN    (rstN),
    .ready   (ready),
    .rd_valid(rd_valid),
    .rD      (rD)
);

//--- sim/tb_serial_slave.sv
`timescale 1ns/1ps
/* serial bus slave testbench with clock, reset, LFSR stimulus,
   check task and directed read/write tests */
module tb_serial_slave
    import serial_bus_pkg::*;
();
    localparam int          TIMEOUT      = 200;
    localparam int          QUIET_CYCLES = 60;
    localparam logic [31:0] SEED         = 32'h1b24_058c;

    logic clk;
    logic rstN;
    logic control;
    logic wD;
    logic valid;
    logic last;
    logic rD;
    logic rd_valid;
    logic ready;

    logic [31:0] lfsr_q;
    // words the slave should hold, filled as writes are accepted
    data_t       model [MEM_DEPTH];

    serial_slave #(
        .SLAVE_ID    (1),
        .ACCESS_DELAY(2)
    ) uut (
        .clk     (clk),
        .rstN    (rstN),
        .control (control),
        .wD      (wD),
        .valid   (valid),
        .last    (last),
        .rD      (rD),
        .rd_valid(rd_valid),
        .ready   (ready)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // taps 32, 22, 2, 1
    function automatic logic next_rand_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic data_t random_word();
        data_t w;
        for (int b = 0; b < DATA_WIDTH; b++) begin
            w = {w[DATA_WIDTH-2:0], next_rand_bit()};
        end
        return w;
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    task automatic wait_ready(input logic level, input string name);
        int cycles;
        cycles = 0;
        while (ready !== level) begin
            if (cycles == TIMEOUT) begin
                $display("%s: ready never went to %0b within %0d cycles", name, level, TIMEOUT);
                abort_run();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic wait_rd_valid(input string name);
        int cycles;
        cycles = 0;
        while (rd_valid !== 1'b1) begin
            if (cycles == TIMEOUT) begin
                $display("%s: no read data came out within %0d cycles", name, TIMEOUT);
                abort_run();
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    // one control frame, msb first, once the slave is ready
    task automatic send_frame(input logic [2:0] start, input slave_id_t id,
                              input logic write, input logic burst, input addr_t addr);
        ctrl_frame_t frame;
        frame.start = start;
        frame.id    = id;
        frame.write = write;
        frame.burst = burst;
        frame.addr  = addr;
        wait_ready(1'b1, "send_frame");
        for (int i = FRAME_BITS - 1; i >= 0; i--) begin
            control = frame[i];
            @(negedge clk);
        end
        control = 1'b0;
    endtask

    // pauses put an idle cycle with inverted wD before some bits
    task automatic drive_word(input data_t w, input logic word_is_last, input bit pauses);
        for (int b = DATA_WIDTH - 1; b >= 0; b--) begin
            if (pauses && next_rand_bit()) begin
                valid = 1'b0;
                wD    = ~w[b];
                last  = 1'b0;
                @(negedge clk);
            end
            valid = 1'b1;
            wD    = w[b];
            last  = word_is_last && (b == 0);
            @(negedge clk);
        end
        valid = 1'b0;
        wD    = 1'b0;
        last  = 1'b0;
    endtask

    task automatic write_words(input string name, input addr_t addr, input int count,
                               input bit pauses);
        data_t w;
        send_frame(START_CODE, 2'd1, 1'b1, count > 1, addr);
        wait_ready(1'b0, name);
        // write phase opens on the edge after the command is taken
        @(negedge clk);
        for (int k = 0; k < count; k++) begin
            w = random_word();
            model[addr_t'(addr + k)] = w;
            // a single write must end on its burst flag alone
            drive_word(w, (count > 1) && (k == count - 1), pauses);
        end
        wait_ready(1'b1, name);
    endtask

    task automatic read_words(input string name, input addr_t addr, input int count);
        data_t got;
        send_frame(START_CODE, 2'd1, 1'b0, count > 1, addr);
        for (int k = 0; k < count; k++) begin
            // last is held through the final word of a burst
            last = (count > 1) && (k == count - 1);
            wait_rd_valid(name);
            for (int b = 0; b < DATA_WIDTH; b++) begin
                check(name, 1, rd_valid);
                got = {got[DATA_WIDTH-2:0], rD};
                @(negedge clk);
            end
            check(name, model[addr_t'(addr + k)], got);
        end
        last = 1'b0;
        wait_ready(1'b1, name);
    endtask

    // slave must stay idle with no read bits
    task automatic expect_quiet(input string name, input int cycles);
        for (int c = 0; c < cycles; c++) begin
            check(name, 1, ready);
            check(name, 0, rd_valid);
            @(negedge clk);
        end
    endtask

    task automatic test_single();
        write_words("single", 8'h10, 1, 1'b0);
        read_words("single", 8'h10, 1);
    endtask

    task automatic test_burst();
        write_words("burst", 8'h20, 4, 1'b0);
        read_words("burst", 8'h20, 4);
    endtask

    task automatic test_valid_pauses();
        write_words("valid_pauses", 8'h30, 1, 1'b1);
        read_words("valid_pauses", 8'h30, 1);
    endtask

    task automatic test_wrong_id();
        send_frame(START_CODE, 2'd2, 1'b1, 1'b0, 8'h10);
        check("wrong_id", 1, ready);
        drive_word(random_word(), 1'b1, 1'b0);
        expect_quiet("wrong_id", 4);
        send_frame(START_CODE, 2'd2, 1'b0, 1'b0, 8'h10);
        expect_quiet("wrong_id", QUIET_CYCLES);
        read_words("wrong_id", 8'h10, 1);
    endtask

    task automatic test_wrong_start();
        send_frame(3'b101, 2'd1, 1'b0, 1'b0, 8'h22);
        check("wrong_start", 1, ready);
        read_words("wrong_start", 8'h22, 1);
    endtask

    initial begin
        rstN    = 1'b0;
        control = 1'b0;
        wD      = 1'b0;
        valid   = 1'b0;
        last    = 1'b0;
        lfsr_q  = SEED;
        repeat (8) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        check("reset", 1, ready);
        check("reset", 0, rd_valid);
        test_single();
        test_burst();
        test_valid_pauses();
        test_wrong_id();
        test_wrong_start();
        $display("Everything OK");
        $finish;
    end

endmodule

//--- vlog.f
rtl/serial_bus_pkg.sv
rtl/frame_receiver.sv
rtl/write_deserializer.sv
rtl/slave_controller.sv
rtl/slave_memory.sv
rtl/read_serializer.sv
rtl/serial_slave.sv
sim/serial_slave_assertions.sv
sim/tb_serial_slave.sv
